// ==== common/mmu_config.svh ====
/*
 * Fixed widths and sizes of the paging unit: Y bus, virtual address,
 * page number, in-page offset, page count and arbiter opcode
 */

`ifndef MMU_CONFIG_SVH
`define MMU_CONFIG_SVH

// --------------------------------------------------------------------------
// Bus and address widths
// --------------------------------------------------------------------------
`define MMU_DATA_W   32         // Y bus word
`define MMU_VADDR_W  20         // Virtual and physical address

// Virtual address splits into page and offset
`define MMU_PAGE_W   10         // Page or frame number, upper address bits
`define MMU_OFFS_W   10         // Offset within a page, lower address bits

// --------------------------------------------------------------------------
// Memory sizes and control widths
// --------------------------------------------------------------------------
`define MMU_PAGES    1024       // Entries in map and per-page bit memories

`define MMU_ARB_OP_W 4          // Bus arbiter opcode

`endif

// ==== common/mmu_ctrl_pkg.sv ====
/*
 * Control encodings of the paging unit: bus arbiter opcodes
 * and the states of the reprioritize fill sequencer
 */

`include "mmu_config.svh"

package mmu_ctrl_pkg;

    // ----------------------------------------------------------------------
    // Arbiter opcodes
    // ----------------------------------------------------------------------
    // Only the writing operations are named; any other code is a read
    // and leaves the dirty bit of the page alone
    typedef enum logic [`MMU_ARB_OP_W-1:0] {
        CCWR  = 4'd2,           // Write to instruction cache
        DCWR  = 4'd4,           // Write to operand cache
        DWR   = 4'd10,          // Write of a result
        RDMWR = 4'd11,          // Read-modify-write
        BTRWR = 4'd12           // Block transfer write
    } arb_op_t;

    // ----------------------------------------------------------------------
    // Reprioritize fill sequencer
    // ----------------------------------------------------------------------
    typedef enum logic [1:0] {
        FILL_IDLE = 2'd0,       // Waiting for a request
        FILL_RUN  = 2'd1,       // Writing ones, one page per cycle
        FILL_DONE = 2'd2        // Acknowledged, waiting for request low
    } fill_state_t;

endpackage

// ==== common/mmu_types_pkg.sv ====
/*
 * Vector types of the paging unit: bus words, addresses,
 * page numbers, offsets and page map entries
 */

`include "mmu_config.svh"

package mmu_types_pkg;

    // Y bus word as seen by every loadable register
    typedef logic [`MMU_DATA_W-1:0]  data_t;

    // Virtual address before translation, physical after
    typedef logic [`MMU_VADDR_W-1:0] vaddr_t;

    // Page number, also used for physical frames
    typedef logic [`MMU_PAGE_W-1:0]  page_t;

    // Offset within a page, passed through untranslated
    typedef logic [`MMU_OFFS_W-1:0]  offs_t;

    // Page map entry
    // Upper page_t bits hold the frame, lower bits are stored
    // with the entry and read back on o_map_entry only
    typedef logic [`MMU_VADDR_W-1:0] map_entry_t;

endpackage

// ==== files.f ====
+incdir+common
common/mmu_types_pkg.sv
common/mmu_ctrl_pkg.sv
rtl/paging/page_translate.sv
rtl/paging/page_attr.sv
rtl/paging/reprio_fill.sv
rtl/paging_unit.sv
test/paging_unit_sva.sv
test/paging_unit_tb.sv

// ==== rtl/paging/page_attr.sv ====
/*
 * Page index register and the per-page used and dirty bits,
 * set by bus accesses or written from the Y bus
 */

`timescale 1ns/1ps
`include "mmu_config.svh"

module page_attr (
    input  logic                  clk,
    input  logic                  reset,
    input  mmu_types_pkg::data_t  i_y,          // Y bus word
    input  mmu_types_pkg::page_t  i_frame,      // Translated frame
    input  logic                  i_access,     // Bus access, wins over strobes
    input  mmu_ctrl_pkg::arb_op_t i_arb_op,     // Opcode of the access
    input  logic                  i_physpg_wr,  // Page index from Y[19:10]
    input  logic                  i_attr_wr,    // Used = Y[1], dirty = Y[2]
    output mmu_types_pkg::page_t  o_page_index,
    output logic                  o_page_used,
    output logic                  o_page_dirty
);

    mmu_types_pkg::page_t page_index;           // Physical page register
    logic                 op_write;             // Access modifies the page
    logic                 pg_used  [`MMU_PAGES];  // Referenced bits
    logic                 pg_dirty [`MMU_PAGES];  // Modified bits

    // ----------------------------------------------------------------------
    // Opcode classification
    // ----------------------------------------------------------------------
    always_comb begin
        case (i_arb_op)
            mmu_ctrl_pkg::CCWR,
            mmu_ctrl_pkg::DCWR,
            mmu_ctrl_pkg::DWR,
            mmu_ctrl_pkg::RDMWR,
            mmu_ctrl_pkg::BTRWR: op_write = 1'b1;
            default:             op_write = 1'b0;   // Any read
        endcase
    end

    // ----------------------------------------------------------------------
    // Page index register
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            page_index <= '0;
        end else if (i_access) begin
            page_index <= i_frame;                  // Follows the access
        end else if (i_physpg_wr) begin
            page_index <= i_y[`MMU_VADDR_W-1:`MMU_OFFS_W];
        end
    end

    // ----------------------------------------------------------------------
    // Used and dirty bit memories
    // ----------------------------------------------------------------------
    // An access marks the frame it touches, the direct write goes to
    // the page selected by the index register
    always_ff @(posedge clk) begin
        if (i_access) begin
            pg_used[i_frame] <= 1'b1;
            if (op_write) begin
                pg_dirty[i_frame] <= 1'b1;
            end
        end else if (i_attr_wr) begin
            pg_used[page_index]  <= i_y[1];
            pg_dirty[page_index] <= i_y[2];
        end
    end

    assign o_page_index = page_index;
    assign o_page_used  = pg_used[page_index];
    assign o_page_dirty = pg_dirty[page_index];

endmodule

// ==== rtl/paging/page_translate.sv ====
/*
 * Executive address register, page map memory and
 * virtual to physical address translation
 */

`timescale 1ns/1ps
`include "mmu_config.svh"

module page_translate (
    input  logic                      clk,
    input  logic                      reset,
    input  mmu_types_pkg::data_t      i_y,          // Y bus word
    input  logic                      i_ureg_wr,    // Load address register
    input  logic                      i_map_wr,     // Write map at current page
    input  logic                      i_no_paging,  // Frame = virtual page
    output mmu_types_pkg::page_t      o_frame,
    output mmu_types_pkg::vaddr_t     o_physad,
    output mmu_types_pkg::map_entry_t o_map_entry
);

    mmu_types_pkg::vaddr_t     ureg;                // Executive address
    mmu_types_pkg::page_t      vpage;               // Virtual page field
    mmu_types_pkg::offs_t      voffs;               // In-page offset field
    mmu_types_pkg::map_entry_t map_rd;              // Entry at vpage
    mmu_types_pkg::map_entry_t pg_map [`MMU_PAGES]; // Page map

    assign vpage = ureg[`MMU_VADDR_W-1:`MMU_OFFS_W];
    assign voffs = ureg[`MMU_OFFS_W-1:0];

    // ----------------------------------------------------------------------
    // Address register
    // ----------------------------------------------------------------------
    // Only the low address bits take part in paging
    always_ff @(posedge clk) begin
        if (reset) begin
            ureg <= '0;
        end else if (i_ureg_wr) begin
            ureg <= i_y[`MMU_VADDR_W-1:0];
        end
    end

    // ----------------------------------------------------------------------
    // Page map
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (i_map_wr) begin
            pg_map[vpage] <= i_y[`MMU_VADDR_W-1:0];     // Entry at old ureg page
        end
    end

    assign map_rd = pg_map[vpage];                      // Asynchronous read

    // ----------------------------------------------------------------------
    // Translation
    // ----------------------------------------------------------------------
    always_comb begin
        if (i_no_paging) begin
            o_frame = vpage;                            // Identity mapping
        end else begin
            o_frame = map_rd[`MMU_VADDR_W-1 -: `MMU_PAGE_W];
        end
    end

    assign o_physad    = {o_frame, voffs};              // Offset passes through
    assign o_map_entry = map_rd;

endmodule

// ==== rtl/paging/reprio_fill.sv ====
/*
 * Reprioritize bit memory with its fill sequencer, which writes ones
 * from the page index up to the last page under a req/ack handshake
 */

`timescale 1ns/1ps
`include "mmu_config.svh"

module reprio_fill (
    input  logic                 clk,
    input  logic                 reset,
    input  mmu_types_pkg::data_t i_y,           // Bit 0 is the written value
    input  mmu_types_pkg::page_t i_page_index,  // Selected page, fill start
    input  logic                 i_reprio_wr,   // Ignored during a fill
    input  logic                 i_fill_req,    // Four-phase request
    output logic                 o_fill_ack,    // Four-phase acknowledge
    output logic                 o_reprio       // Bit at the page index
);

    localparam mmu_types_pkg::page_t last_page = mmu_types_pkg::page_t'(`MMU_PAGES - 1);

    mmu_ctrl_pkg::fill_state_t state;           // Sequencer state
    mmu_ctrl_pkg::fill_state_t state_nxt;
    mmu_types_pkg::page_t      fcnt;            // Page being filled
    logic                      fill_last;       // Counter at last page
    logic                      pg_reprio [`MMU_PAGES];

    assign fill_last = (fcnt == last_page);

    // ----------------------------------------------------------------------
    // Fill sequencer
    // ----------------------------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            mmu_ctrl_pkg::FILL_IDLE: begin
                if (i_fill_req) begin
                    state_nxt = mmu_ctrl_pkg::FILL_RUN;
                end
            end
            mmu_ctrl_pkg::FILL_RUN: begin
                if (fill_last) begin
                    state_nxt = mmu_ctrl_pkg::FILL_DONE;    // Last write this cycle
                end
            end
            mmu_ctrl_pkg::FILL_DONE: begin
                // Held request is the same fill, not a new one
                if (!i_fill_req) begin
                    state_nxt = mmu_ctrl_pkg::FILL_IDLE;
                end
            end
            default: state_nxt = mmu_ctrl_pkg::FILL_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mmu_ctrl_pkg::FILL_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Start page captured with the request, then one step per cycle
    always_ff @(posedge clk) begin
        if (state == mmu_ctrl_pkg::FILL_IDLE && i_fill_req) begin
            fcnt <= i_page_index;
        end else if (state == mmu_ctrl_pkg::FILL_RUN) begin
            fcnt <= fcnt + 1'b1;
        end
    end

    assign o_fill_ack = (state == mmu_ctrl_pkg::FILL_DONE);

    // ----------------------------------------------------------------------
    // Reprioritize bit memory
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (state == mmu_ctrl_pkg::FILL_RUN) begin
            pg_reprio[fcnt] <= 1'b1;                // Fill with ones
        end else if (i_reprio_wr) begin
            pg_reprio[i_page_index] <= i_y[0];
        end
    end

    assign o_reprio = pg_reprio[i_page_index];

endmodule

// ==== rtl/paging_unit.sv ====
/*
 * Paging unit top level: address translation, page attributes
 * and the reprioritize bit fill, joined by wires
 */

`timescale 1ns/1ps

module paging_unit (
    input  logic                      clk,
    input  logic                      reset,

    // Y bus and register strobes
    input  mmu_types_pkg::data_t      i_y,          // Y bus word
    input  logic                      i_ureg_wr,    // Load address register
    input  logic                      i_map_wr,     // Write page map entry
    input  logic                      i_no_paging,  // Bypass translation

    // Bus access classification
    input  logic                      i_access,     // Bus access request
    input  mmu_ctrl_pkg::arb_op_t     i_arb_op,     // Opcode of the access

    // Page attribute strobes
    input  logic                      i_physpg_wr,  // Load page index
    input  logic                      i_attr_wr,    // Write used and dirty
    input  logic                      i_reprio_wr,  // Write reprioritize bit

    // Fill handshake
    input  logic                      i_fill_req,
    output logic                      o_fill_ack,

    // Results
    output mmu_types_pkg::vaddr_t     o_physad,     // Translated address
    output mmu_types_pkg::map_entry_t o_map_entry,  // Entry at current page
    output mmu_types_pkg::page_t      o_page_index,
    output logic                      o_page_used,
    output logic                      o_page_dirty,
    output logic                      o_reprio
);

    mmu_types_pkg::page_t frame;        // Translated frame of the address
    mmu_types_pkg::page_t page_index;   // Selects per-page bits

    // ----------------------------------------------------------------------
    // Address register, page map, translation
    // ----------------------------------------------------------------------
    page_translate u_translate (
        .clk         (clk),
        .reset       (reset),
        .i_y         (i_y),
        .i_ureg_wr   (i_ureg_wr),
        .i_map_wr    (i_map_wr),
        .i_no_paging (i_no_paging),
        .o_frame     (frame),
        .o_physad    (o_physad),
        .o_map_entry (o_map_entry)
    );

    // ----------------------------------------------------------------------
    // Page index, used and dirty bits
    // ----------------------------------------------------------------------
    page_attr u_attr (
        .clk          (clk),
        .reset        (reset),
        .i_y          (i_y),
        .i_frame      (frame),
        .i_access     (i_access),
        .i_arb_op     (i_arb_op),
        .i_physpg_wr  (i_physpg_wr),
        .i_attr_wr    (i_attr_wr),
        .o_page_index (page_index),
        .o_page_used  (o_page_used),
        .o_page_dirty (o_page_dirty)
    );

    assign o_page_index = page_index;

    // ----------------------------------------------------------------------
    // Reprioritize bits and fill sequencer
    // ----------------------------------------------------------------------
    reprio_fill u_reprio (
        .clk          (clk),
        .reset        (reset),
        .i_y          (i_y),
        .i_page_index (page_index),
        .i_reprio_wr  (i_reprio_wr),
        .i_fill_req   (i_fill_req),
        .o_fill_ack   (o_fill_ack),
        .o_reprio     (o_reprio)
    );

endmodule

// ==== test/paging_unit_sva.sv ====
/*
 * Assertions on the reprioritize fill handshake and its reset state,
 * bound into every reprio_fill instance
 */

`timescale 1ns/1ps

module paging_unit_sva (
    input logic clk,
    input logic reset,
    input logic i_fill_req,                 // Request as seen by the sequencer
    input logic i_fill_ack                  // Acknowledge driven by the sequencer
);

    // Acknowledge may only come up for a pending request
    ack_rise_with_req: assert property (
        @(posedge clk) disable iff (reset)
        $rose(i_fill_ack) |-> i_fill_req
    ) else $error("fill acknowledge rose without a request");

    // Four-phase rule, no early release
    ack_held_with_req: assert property (
        @(posedge clk) disable iff (reset)
        (i_fill_ack && i_fill_req) |=> i_fill_ack
    ) else $error("fill acknowledge fell while request still high");

    // Sequencer comes out of reset idle
    ack_low_after_reset: assert property (
        @(posedge clk)
        reset |=> !i_fill_ack
    ) else $error("fill acknowledge high after reset");

endmodule

bind reprio_fill paging_unit_sva u_sva (
    .clk        (clk),
    .reset      (reset),
    .i_fill_req (i_fill_req),
    .i_fill_ack (o_fill_ack)
);

// ==== test/paging_unit_tb.sv ====
/*
 * Testbench of the paging unit: clock, reset, a stimulus table with
 * expected values from a reference model, checking loop and report
 */

`timescale 1ns/1ps
`include "mmu_config.svh"

module paging_unit_tb;

    localparam int MAX_ROWS     = 64;
    localparam int FILL_TIMEOUT = 1500;     // Longest fill is 1024 pages

    typedef enum logic [2:0] {
        K_UREG, K_MAP, K_ACCESS, K_PHYSPG, K_ATTR, K_REPRIO, K_FILL
    } row_kind_t;

    logic                      clk;
    logic                      reset;
    mmu_types_pkg::data_t      i_y;
    logic                      i_ureg_wr;
    logic                      i_map_wr;
    logic                      i_no_paging;
    logic                      i_access;
    mmu_ctrl_pkg::arb_op_t     i_arb_op;
    logic                      i_physpg_wr;
    logic                      i_attr_wr;
    logic                      i_reprio_wr;
    logic                      i_fill_req;
    logic                      o_fill_ack;
    mmu_types_pkg::vaddr_t     o_physad;
    mmu_types_pkg::map_entry_t o_map_entry;
    mmu_types_pkg::page_t      o_page_index;
    logic                      o_page_used;
    logic                      o_page_dirty;
    logic                      o_reprio;

    // Stimulus and expected values, one entry per row
    row_kind_t                 row_kind   [MAX_ROWS];
    mmu_types_pkg::data_t      row_data   [MAX_ROWS];
    mmu_ctrl_pkg::arb_op_t     row_op     [MAX_ROWS];
    logic                      row_nopg   [MAX_ROWS];
    mmu_types_pkg::vaddr_t     exp_physad [MAX_ROWS];
    mmu_types_pkg::map_entry_t exp_entry  [MAX_ROWS];
    mmu_types_pkg::page_t      exp_index  [MAX_ROWS];
    logic                      exp_used   [MAX_ROWS];
    logic                      exp_dirty  [MAX_ROWS];
    logic                      exp_reprio [MAX_ROWS];

    // Reference model, X where the DUT memory was never written
    mmu_types_pkg::vaddr_t     m_ureg;
    mmu_types_pkg::page_t      m_index;
    mmu_types_pkg::map_entry_t m_map    [`MMU_PAGES];
    logic                      m_used   [`MMU_PAGES];
    logic                      m_dirty  [`MMU_PAGES];
    logic                      m_reprio [`MMU_PAGES];

    logic [3:0] rd_codes [11] = '{4'd0, 4'd1, 4'd3, 4'd5, 4'd6, 4'd7, 4'd8, 4'd9,
                                  4'd13, 4'd14, 4'd15};
    logic [3:0] wr_codes [5]  = '{4'd2, 4'd4, 4'd10, 4'd11, 4'd12};

    integer seed;
    int     n_rows;
    int     errors;
    int     timeouts;

    paging_unit UUT (
        .clk (clk), .reset (reset), .i_y (i_y),
        .i_ureg_wr (i_ureg_wr), .i_map_wr (i_map_wr), .i_no_paging (i_no_paging),
        .i_access (i_access), .i_arb_op (i_arb_op), .i_physpg_wr (i_physpg_wr),
        .i_attr_wr (i_attr_wr), .i_reprio_wr (i_reprio_wr),
        .i_fill_req (i_fill_req), .o_fill_ack (o_fill_ack),
        .o_physad (o_physad), .o_map_entry (o_map_entry),
        .o_page_index (o_page_index), .o_page_used (o_page_used),
        .o_page_dirty (o_page_dirty), .o_reprio (o_reprio)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;             // 20 ns period
    end

    // ----------------------------------------------------------------------------
    // Reference model and table construction
    // ----------------------------------------------------------------------------
    function automatic logic is_write_op(input logic [3:0] op);
        case (op)
            4'd2, 4'd4, 4'd10, 4'd11, 4'd12: return 1'b1;
            default:                         return 1'b0;
        endcase
    endfunction

    function automatic mmu_types_pkg::data_t place_page(input mmu_types_pkg::data_t d,
                                                         input mmu_types_pkg::page_t p);
        d[`MMU_VADDR_W-1:`MMU_OFFS_W] = p;  // Page field of an address
        return d;
    endfunction

    task automatic add_row(input row_kind_t kind, input mmu_types_pkg::data_t d,
                           input logic [3:0] op, input logic nopg);
        mmu_types_pkg::page_t vpage;
        mmu_types_pkg::page_t frame;
        int                   pg;
        vpage = m_ureg[`MMU_VADDR_W-1:`MMU_OFFS_W];
        case (kind)
            K_UREG:   m_ureg = d[`MMU_VADDR_W-1:0];
            K_MAP:    m_map[vpage] = d[`MMU_VADDR_W-1:0];
            K_ACCESS: begin
                frame = nopg ? vpage : m_map[vpage][`MMU_VADDR_W-1 -: `MMU_PAGE_W];
                m_index = frame;
                m_used[frame] = 1'b1;
                if (is_write_op(op)) begin
                    m_dirty[frame] = 1'b1;  // Reads leave it alone
                end
            end
            K_PHYSPG: m_index = d[`MMU_VADDR_W-1:`MMU_OFFS_W];
            K_ATTR: begin
                m_used[m_index]  = d[1];
                m_dirty[m_index] = d[2];
            end
            K_REPRIO: m_reprio[m_index] = d[0];
            K_FILL: begin
                for (pg = m_index; pg < `MMU_PAGES; pg++) begin
                    m_reprio[pg] = 1'b1;    // Index up to last page
                end
            end
            default: ;
        endcase
        vpage = m_ureg[`MMU_VADDR_W-1:`MMU_OFFS_W];
        row_kind[n_rows]   = kind;
        row_data[n_rows]   = d;
        row_op[n_rows]     = mmu_ctrl_pkg::arb_op_t'(op);
        row_nopg[n_rows]   = nopg;
        exp_physad[n_rows] = nopg ? m_ureg
                           : {m_map[vpage][`MMU_VADDR_W-1 -: `MMU_PAGE_W],
                              m_ureg[`MMU_OFFS_W-1:0]};
        exp_entry[n_rows]  = m_map[vpage];
        exp_index[n_rows]  = m_index;
        exp_used[n_rows]   = m_used[m_index];
        exp_dirty[n_rows]  = m_dirty[m_index];
        exp_reprio[n_rows] = m_reprio[m_index];
        n_rows++;
    endtask

    // Page index row, then the row that uses it
    task automatic select_page(input mmu_types_pkg::page_t p);
        add_row(K_PHYSPG, place_page($random(seed), p), 4'd0, 1'b0);
    endtask

    task automatic build_table();
        mmu_types_pkg::data_t d;
        mmu_types_pkg::page_t pa;
        mmu_types_pkg::page_t p;
        int                   i;
        for (i = 0; i < `MMU_PAGES; i++) begin
            m_map[i]    = 'x;
            m_used[i]   = 1'bx;
            m_dirty[i]  = 1'bx;
            m_reprio[i] = 1'bx;
        end
        m_ureg  = '0;
        m_index = '0;
        // Translation and access classification
        for (i = 0; i < 4; i++) begin
            add_row(K_UREG, $random(seed), 4'd0, 1'b0);
            add_row(K_MAP, $random(seed), 4'd0, 1'b0);
            select_page(m_map[m_ureg[`MMU_VADDR_W-1:`MMU_OFFS_W]][`MMU_VADDR_W-1 -: `MMU_PAGE_W]);
            d = $random(seed);
            d[2:1] = 2'b00;                 // Start clean
            add_row(K_ATTR, d, 4'd0, 1'b0);
            add_row(K_ACCESS, $random(seed), rd_codes[$unsigned($random(seed)) % 11], 1'b0);
            add_row(K_ACCESS, $random(seed), wr_codes[$unsigned($random(seed)) % 5], 1'b0);
            add_row(K_ACCESS, $random(seed), rd_codes[$unsigned($random(seed)) % 11], 1'b0);
            add_row(K_ACCESS, $random(seed), rd_codes[$unsigned($random(seed)) % 11], 1'b1);
        end
        // Direct attribute writes on two pages
        pa = $random(seed);
        select_page(pa);
        add_row(K_ATTR, $random(seed), 4'd0, 1'b0);
        select_page(pa ^ 10'h155);
        add_row(K_ATTR, $random(seed), 4'd0, 1'b0);
        select_page(pa);
        // Reprioritize writes
        pa = $random(seed);
        select_page(pa);
        add_row(K_REPRIO, $random(seed), 4'd0, 1'b0);
        select_page(pa ^ 10'h001);
        add_row(K_REPRIO, $random(seed), 4'd0, 1'b0);
        // Fill from p, with cleared pages on both sides
        p = 10'd600 + ($unsigned($random(seed)) % 100);
        d = $random(seed);
        d[0] = 1'b0;
        select_page(p - 10'd5);
        add_row(K_REPRIO, d, 4'd0, 1'b0);
        select_page(p - 10'd200);
        add_row(K_REPRIO, d, 4'd0, 1'b0);
        select_page(p + 10'd3);
        add_row(K_REPRIO, d, 4'd0, 1'b0);
        select_page(p + 10'd100);
        add_row(K_REPRIO, d, 4'd0, 1'b0);
        select_page(p);
        add_row(K_FILL, $random(seed), 4'd0, 1'b0);
        select_page(p + 10'd3);
        select_page(p + 10'd100);
        select_page(10'd1023);
        select_page(p - 10'd5);
        select_page(p - 10'd200);
        // Second fill after the handshake is released
        add_row(K_FILL, $random(seed), 4'd0, 1'b0);
        select_page(p - 10'd5);
    endtask

    // ----------------------------------------------------------------------------
    // Driving and checking
    // ----------------------------------------------------------------------------
    task automatic report_mismatch(input int r, input string what,
                                   input logic [31:0] got, input logic [31:0] exp);
        $display("CHECK FAILED at %0t ns: row %0d %s is %h, expected %h",
                 $time, r, what, got, exp);
        errors++;
    endtask

    task automatic check_row(input int r);
        if (!$isunknown(exp_physad[r]) && o_physad !== exp_physad[r]) begin
            report_mismatch(r, "o_physad", o_physad, exp_physad[r]);
        end
        if (!$isunknown(exp_entry[r]) && o_map_entry !== exp_entry[r]) begin
            report_mismatch(r, "o_map_entry", o_map_entry, exp_entry[r]);
        end
        if (o_page_index !== exp_index[r]) begin
            report_mismatch(r, "o_page_index", o_page_index, exp_index[r]);
        end
        if (!$isunknown(exp_used[r]) && o_page_used !== exp_used[r]) begin
            report_mismatch(r, "o_page_used", o_page_used, exp_used[r]);
        end
        if (!$isunknown(exp_dirty[r]) && o_page_dirty !== exp_dirty[r]) begin
            report_mismatch(r, "o_page_dirty", o_page_dirty, exp_dirty[r]);
        end
        if (!$isunknown(exp_reprio[r]) && o_reprio !== exp_reprio[r]) begin
            report_mismatch(r, "o_reprio", o_reprio, exp_reprio[r]);
        end
    endtask

    // Four-phase handshake, holding the request a few cycles past the ack
    task automatic run_fill(input int r);
        int cnt;
        i_fill_req = 1'b1;
        cnt = 0;
        @(negedge clk);
        while (o_fill_ack !== 1'b1 && cnt < FILL_TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (o_fill_ack !== 1'b1) begin
            $display("ERROR at %0t ns: fill acknowledge never arrived", $time);
            timeouts++;
            i_fill_req = 1'b0;
        end else begin
            if (o_reprio !== 1'b1) begin
                report_mismatch(r, "o_reprio at fill start", o_reprio, 1);
            end
            repeat (3) begin
                @(negedge clk);
                if (o_fill_ack !== 1'b1) begin
                    report_mismatch(r, "o_fill_ack with request held", o_fill_ack, 1);
                end
            end
            i_fill_req = 1'b0;
            cnt = 0;
            @(negedge clk);
            while (o_fill_ack !== 1'b0 && cnt < FILL_TIMEOUT) begin
                @(negedge clk);
                cnt++;
            end
            if (o_fill_ack !== 1'b0) begin
                $display("ERROR at %0t ns: fill acknowledge never dropped", $time);
                timeouts++;
            end
        end
    endtask

    // Starts and ends on a falling edge
    task automatic apply_row(input int r);
        i_y         = row_data[r];
        i_arb_op    = row_op[r];
        i_no_paging = row_nopg[r];
        if (row_kind[r] == K_FILL) begin
            run_fill(r);
        end else begin
            i_ureg_wr   = (row_kind[r] == K_UREG);
            i_map_wr    = (row_kind[r] == K_MAP);
            i_access    = (row_kind[r] == K_ACCESS);
            i_physpg_wr = (row_kind[r] == K_PHYSPG);
            i_attr_wr   = (row_kind[r] == K_ATTR);
            i_reprio_wr = (row_kind[r] == K_REPRIO);
            @(negedge clk);
            i_ureg_wr   = 1'b0;
            i_map_wr    = 1'b0;
            i_access    = 1'b0;
            i_physpg_wr = 1'b0;
            i_attr_wr   = 1'b0;
            i_reprio_wr = 1'b0;
            @(negedge clk);
        end
        check_row(r);
    endtask

    initial begin
        int r;
        seed        = 9;
        n_rows      = 0;
        errors      = 0;
        timeouts    = 0;
        reset       = 1'b1;
        i_y         = '0;
        i_ureg_wr   = 1'b0;
        i_map_wr    = 1'b0;
        i_no_paging = 1'b0;
        i_access    = 1'b0;
        i_arb_op    = mmu_ctrl_pkg::arb_op_t'(4'd0);
        i_physpg_wr = 1'b0;
        i_attr_wr   = 1'b0;
        i_reprio_wr = 1'b0;
        i_fill_req  = 1'b0;
        build_table();
        repeat (16) @(negedge clk);         // 16 cycles in reset
        reset = 1'b0;
        @(negedge clk);
        for (r = 0; r < n_rows; r++) begin
            apply_row(r);
            if (timeouts != 0) begin
                break;                      // Handshake is stuck
            end
        end
        $display("Rows %0d, check errors %0d, timeouts %0d", n_rows, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
